// File: files.f
+incdir+.
exec_pkg.sv
reg_file_if.sv
register_file.sv
alu.sv
exec_control.sv
retire_counter.sv
exec_core_top.sv
tb_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_exec_core -f files.f -o sim_exec_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_exec_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation reported errors, see $LOG"
    exit 1
fi

echo "Simulation clean, see $LOG"
exit 0

// File: tb_ref_model.svh
logic [DATA_W-1:0] shadow_regs [NUM_REGS];  // Shadow copy of the register file
logic [CNT_W-1:0]  model_retired;

function automatic void shadow_reset();
    for (int i = 0; i < NUM_REGS; i++)
    begin
        shadow_regs[i] = DATA_W'(i);  // Register i starts at i
    end
    model_retired = '0;
endfunction

function automatic void predict_instr(input logic [31:0] word, output logic [4:0] dest,
                                      output logic [31:0] value, output logic legal);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] zext;
    a     = shadow_regs[word[25:21]];
    b     = shadow_regs[word[20:16]];
    sext  = {{16{word[15]}}, word[15:0]};
    zext  = {16'h0000, word[15:0]};
    dest  = (word[31:26] == OP_RTYPE) ? word[15:11] : word[20:16];  // rd or rt
    legal = 1'b1;
    value = '0;
    case (word[31:26])
        OP_RTYPE:
        begin
            case (word[5:0])
                FN_ADD:  value = a + b;
                FN_SUB:  value = a - b;
                FN_AND:  value = a & b;
                FN_OR:   value = a | b;
                FN_XOR:  value = a ^ b;
                FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: legal = 1'b0;
            endcase
        end
        OP_ADDI: value = a + sext;
        OP_ANDI: value = a & zext;
        OP_ORI:  value = a | zext;
        default: legal = 1'b0;
    endcase
    if (!legal || dest == 5'd0)
    begin
        value = shadow_regs[dest];  // Destination keeps its old contents
    end
endfunction

function automatic void apply_shadow(input logic [4:0] dest, input logic [31:0] value,
                                     input logic legal);
    if (legal)
    begin
        model_retired = model_retired + 16'd1;
        if (dest != 5'd0)
        begin
            shadow_regs[dest] = value;
        end
    end
endfunction

function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [4:0] rd);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// File: tb_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;
    import exec_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int CLK_HALF    = 2;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_INSTR   = NUM_RANDOM + 16;      // Random plus directed
    localparam int WATCHDOG_NS = NUM_INSTR * 40 + 2000;
    localparam int WAIT_LIMIT  = 20;                   // Cycles

    typedef struct packed {
        logic [4:0]        dest;
        logic [DATA_W-1:0] value;
        logic              legal;
        logic [CNT_W-1:0]  retired;
        logic [63:0]       start_ns;
    } expect_t;

    logic              i_clk;
    logic              i_reset;
    logic              i_start;
    logic [DATA_W-1:0] i_instr;
    logic [REG_AW-1:0] i_dbg_addr;
    logic              o_busy;
    logic              o_done;
    logic              o_illegal;
    logic [DATA_W-1:0] o_dbg_data;
    logic [CNT_W-1:0]  o_retired;

    expect_t    expect_q [$];
    logic       checking;
    int         error_count;
    int         check_count;
    int         tests_run;
    int         test_start_errors;
    integer     seed;
    logic [5:0] rtype_fns [6];

    `include "tb_ref_model.svh"

    exec_core_top u_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_start    (i_start),
        .i_instr    (i_instr),
        .i_dbg_addr (i_dbg_addr),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_illegal  (o_illegal),
        .o_dbg_data (o_dbg_data),
        .o_retired  (o_retired)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #(CLK_HALF) i_clk = ~i_clk;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before the tests completed", $time);
        $display("Checks failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (o_busy && cycles < WAIT_LIMIT)
        begin
            @(posedge i_clk);
            #1;
            cycles++;
        end
        if (o_busy)
        begin
            $display("DUT still busy after %0d cycles at %0t", WAIT_LIMIT, $time);
            error_count++;
        end
    endtask

    // Entered 1 ns after a rising edge and left 1 ns after the accepting edge
    task automatic issue_instr(input logic [31:0] word);
        expect_t     e;
        logic [4:0]  dest;
        logic [31:0] value;
        logic        legal;
        wait_idle();
        predict_instr(word, dest, value, legal);
        apply_shadow(dest, value, legal);
        e.dest    = dest;
        e.value   = value;
        e.legal   = legal;
        e.retired = model_retired;
        i_start   = 1'b1;
        i_instr   = word;
        @(posedge i_clk);
        e.start_ns = $time;
        expect_q.push_back(e);
        #1;
        i_start = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((expect_q.size() != 0 || checking || o_busy) && cycles < WAIT_LIMIT)
        begin
            @(posedge i_clk);
            #1;
            cycles++;
        end
        if (expect_q.size() != 0 || checking || o_busy)
        begin
            $display("Timed out at %0t waiting for the DUT to finish", $time);
            error_count++;
        end
    endtask

    task automatic sweep_registers(input logic use_index);
        logic [31:0] exp;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            i_dbg_addr = REG_AW'(i);
            #1;
            exp = use_index ? DATA_W'(i) : shadow_regs[i];
            check_value($sformatf("o_dbg_data[r%0d]", i), o_dbg_data, exp);
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic make_random_instr(output logic [31:0] word);
        logic [31:0] pick;
        pick = $random(seed);
        word = $random(seed);
        case (pick[2:0])
            3'd0, 3'd1, 3'd2, 3'd7:
            begin
                word[31:26] = OP_RTYPE;
                word[5:0]   = rtype_fns[int'(pick[10:8]) % 6];
            end
            3'd3: word[31:26] = OP_ADDI;
            3'd4: word[31:26] = pick[8] ? OP_ANDI : OP_ORI;
            3'd5:
            begin
                word[31:26] = OP_RTYPE;
                word[5:0]   = {1'b0, pick[20:16]};  // Below every valid function code
            end
            default: word[31:26] = {1'b1, pick[20:16]};  // Above every valid opcode
        endcase
    endtask

    task automatic report_test(input int num, input string name);
        tests_run++;
        $display("Test %0d %s finished with %0d errors", num, name,
                 error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    // Compares each completed instruction with its queued prediction
    initial
    begin : compare_results
        expect_t     e;
        logic [63:0] lat;
        checking = 1'b0;
        forever
        begin
            @(negedge i_clk);
            if (o_done && expect_q.size() == 0)
            begin
                $display("o_done high at %0t with no instruction pending", $time);
                error_count++;
            end
            else if (o_done)
            begin
                checking = 1'b1;
                e   = expect_q.pop_front();
                lat = (($time + CLK_HALF) - e.start_ns) / CLK_PERIOD;
                check_value("done latency", lat[31:0], 32'd2);
                check_value("o_illegal", {31'b0, o_illegal}, {31'b0, ~e.legal});
                @(posedge i_clk);
                #1;
                i_dbg_addr = e.dest;
                #0.5;
                check_value($sformatf("o_dbg_data[r%0d]", e.dest), o_dbg_data, e.value);
                check_value("o_retired", {16'b0, o_retired}, {16'b0, e.retired});
                checking = 1'b0;
            end
        end
    end

    initial
    begin
        logic [CNT_W-1:0] retired_before;
        logic [31:0]      word;
        seed              = 6985;
        error_count       = 0;
        check_count       = 0;
        tests_run         = 0;
        test_start_errors = 0;
        rtype_fns         = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT};
        i_reset           = 1'b1;
        i_start           = 1'b0;
        i_instr           = '0;
        i_dbg_addr        = '0;
        shadow_reset();
        repeat (16) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        check_value("o_busy", {31'b0, o_busy}, 32'd0);
        check_value("o_done", {31'b0, o_done}, 32'd0);
        check_value("o_illegal", {31'b0, o_illegal}, 32'd0);
        check_value("o_retired", {16'b0, o_retired}, 32'd0);
        sweep_registers(1'b1);
        report_test(1, "reset contents");

        issue_instr(r_word(FN_ADD, 5'd4, 5'd5, 5'd20));
        issue_instr(r_word(FN_SUB, 5'd3, 5'd9, 5'd21));   // Negative result
        issue_instr(r_word(FN_AND, 5'd13, 5'd7, 5'd22));
        issue_instr(r_word(FN_OR, 5'd10, 5'd5, 5'd23));
        issue_instr(r_word(FN_XOR, 5'd15, 5'd6, 5'd24));
        issue_instr(r_word(FN_SLT, 5'd21, 5'd2, 5'd25));
        issue_instr(r_word(FN_SLT, 5'd2, 5'd21, 5'd26));
        wait_drained();
        report_test(2, "R-type operations");

        issue_instr(i_word(OP_ADDI, 5'd20, 5'd27, 16'hFF9C));
        issue_instr(i_word(OP_ADDI, 5'd1, 5'd30, 16'h7FFF));
        issue_instr(i_word(OP_ANDI, 5'd21, 5'd28, 16'hF0F0));
        issue_instr(i_word(OP_ORI, 5'd12, 5'd29, 16'h8001));
        wait_drained();
        report_test(3, "I-type operations");

        issue_instr(r_word(FN_ADD, 5'd5, 5'd6, 5'd0));
        issue_instr(i_word(OP_ADDI, 5'd3, 5'd0, 16'd77));
        issue_instr(i_word(6'd63, 5'd2, 5'd14, 16'h1234));
        issue_instr(r_word(6'd1, 5'd2, 5'd3, 5'd15));
        wait_drained();
        sweep_registers(1'b0);
        report_test(4, "register 0 and illegal");

        retired_before = model_retired;
        issue_instr(r_word(FN_ADD, 5'd8, 5'd9, 5'd16));
        @(posedge i_clk);
        #1;
        check_value("o_busy", {31'b0, o_busy}, 32'd1);
        i_start = 1'b1;
        i_instr = r_word(FN_OR, 5'd1, 5'd2, 5'd17);  // Arrives while busy
        @(posedge i_clk);
        #1;
        i_start = 1'b0;
        wait_drained();
        check_value("o_retired", {16'b0, o_retired}, {16'b0, retired_before + 16'd1});
        sweep_registers(1'b0);
        report_test(5, "ignored start");

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            make_random_instr(word);
            issue_instr(word);
        end
        wait_drained();
        check_value("o_retired", {16'b0, o_retired}, {16'b0, model_retired});
        sweep_registers(1'b0);
        report_test(6, "random run");

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count,
                 error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_top (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_start,
    input  wire  [exec_pkg::DATA_W-1:0]  i_instr,
    input  wire  [exec_pkg::REG_AW-1:0]  i_dbg_addr,
    output logic                         o_busy,
    output logic                         o_done,
    output logic                         o_illegal,
    output logic [exec_pkg::DATA_W-1:0]  o_dbg_data,
    output logic [exec_pkg::CNT_W-1:0]   o_retired
);
    import exec_pkg::*;

    instr_u host_instr;
    instr_u cur_instr;
    logic   legal;
    logic   retire;

    reg_file_if rf ();

    assign host_instr = i_instr;  // Raw word seen through the union

    register_file u_register_file (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data),
        .rf         (rf.storage)
    );

    exec_control u_exec_control (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (i_start),
        .i_instr   (host_instr),
        .i_legal   (legal),
        .rf        (rf.writer),
        .o_instr   (cur_instr),
        .o_busy    (o_busy),
        .o_done    (o_done),
        .o_illegal (o_illegal),
        .o_retire  (retire)
    );

    alu u_alu (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_instr (cur_instr),
        .rf      (rf.datapath),
        .o_legal (legal)
    );

    retire_counter u_retire_counter (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_retire (retire),
        .o_count  (o_retired)
    );

endmodule

`default_nettype wire

// File: retire_counter.sv
`timescale 1ns/1ps
`default_nettype none

module retire_counter (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_retire,
    output logic [exec_pkg::CNT_W-1:0]  o_count
);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_count <= '0;
        end
        else if (i_retire)
        begin
            o_count <= o_count + 1'b1;  // Wraps past all ones
        end
    end

endmodule

`default_nettype wire

// File: exec_control.sv
`timescale 1ns/1ps
`default_nettype none

module exec_control (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_start,
    input  wire exec_pkg::instr_u  i_instr,
    input  wire                    i_legal,
    reg_file_if.writer             rf,
    output exec_pkg::instr_u       o_instr,
    output logic                   o_busy,
    output logic                   o_done,
    output logic                   o_illegal,
    output logic                   o_retire
);
    import exec_pkg::*;

    logic [ST_W-1:0] state;
    logic [ST_W-1:0] state_next;
    logic            accept;
    logic            in_write;

    assign accept   = (state == ST_IDLE) && i_start;  // Start ignored while busy
    assign in_write = (state == ST_WRITE);

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (accept)
                begin
                    state_next = ST_DECODE;
                end
            end
            ST_DECODE: state_next = ST_WRITE;
            ST_WRITE:  state_next = ST_IDLE;
            default:   state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Instruction word held for the whole operation
    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            o_instr <= i_instr;
        end
    end

    // rd for R-type, rt for I-type
    assign rf.wr_addr = (o_instr.r.opcode == OP_RTYPE) ? o_instr.r.rd : o_instr.i.rt;

    assign rf.we     = in_write && i_legal;
    assign o_retire  = in_write && i_legal;
    assign o_illegal = in_write && !i_legal;
    assign o_done    = in_write;                   // One cycle, legal or not
    assign o_busy    = (state != ST_IDLE);         // Falls at the closing edge of WRITE

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire exec_pkg::instr_u i_instr,
    reg_file_if.datapath     rf,
    output logic             o_legal
);
    import exec_pkg::*;

    alu_op_e           op;
    logic [DATA_W-1:0] operand_b;
    logic [DATA_W-1:0] imm_sext;
    logic [DATA_W-1:0] imm_zext;
    logic [DATA_W-1:0] result;

    // rs and rt sit in the same bits in both views
    assign rf.rs_addr = i_instr.r.rs;
    assign rf.rt_addr = i_instr.r.rt;

    assign imm_sext = {{(DATA_W-IMM_W){i_instr.i.imm16[IMM_W-1]}}, i_instr.i.imm16};
    assign imm_zext = {{(DATA_W-IMM_W){1'b0}}, i_instr.i.imm16};

    always_comb
    begin
        op        = ALU_NONE;
        operand_b = rf.rt_data;
        case (i_instr.r.opcode)
            OP_RTYPE:
            begin
                case (i_instr.r.funct)
                    FN_ADD:  op = ALU_ADD;
                    FN_SUB:  op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_SLT:  op = ALU_SLT;
                    default: op = ALU_NONE;
                endcase
            end
            OP_ADDI:
            begin
                op        = ALU_ADD;
                operand_b = imm_sext;
            end
            OP_ANDI:
            begin
                op        = ALU_AND;
                operand_b = imm_zext;
            end
            OP_ORI:
            begin
                op        = ALU_OR;
                operand_b = imm_zext;
            end
            default: op = ALU_NONE;  // Unknown opcode
        endcase
    end

    assign o_legal = (op != ALU_NONE);

    always_comb
    begin
        case (op)
            ALU_ADD: result = rf.rs_data + operand_b;
            ALU_SUB: result = rf.rs_data - operand_b;
            ALU_AND: result = rf.rs_data & operand_b;
            ALU_OR:  result = rf.rs_data | operand_b;
            ALU_XOR: result = rf.rs_data ^ operand_b;
            ALU_SLT: result = {{(DATA_W-1){1'b0}}, $signed(rf.rs_data) < $signed(operand_b)};
            default: result = '0;
        endcase
    end

    // Sources are stable from DECODE on, so the value captured at its end holds in WRITE
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            rf.wr_data <= '0;
        end
        else
        begin
            rf.wr_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire  [exec_pkg::REG_AW-1:0]  i_dbg_addr,
    output logic [exec_pkg::DATA_W-1:0]  o_dbg_data,
    reg_file_if.storage                  rf
);
    import exec_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              wr_ok;

    // Register 0 is never written, so it keeps the zero loaded at reset
    assign wr_ok = rf.we && (rf.wr_addr != '0);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= DATA_W'(i);  // Each register starts at its index
            end
        end
        else if (wr_ok)
        begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    assign rf.rs_data = regs[rf.rs_addr];     // Source A
    assign rf.rt_data = regs[rf.rt_addr];     // Source B
    assign o_dbg_data = regs[i_dbg_addr];     // Debug read, any time

endmodule

`default_nettype wire

// File: reg_file_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_file_if;
    import exec_pkg::*;

    logic [REG_AW-1:0] rs_addr;
    logic [REG_AW-1:0] rt_addr;
    logic [DATA_W-1:0] rs_data;
    logic [DATA_W-1:0] rt_data;
    logic              we;
    logic [REG_AW-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;

    modport storage (
        input  rs_addr, rt_addr, we, wr_addr, wr_data,
        output rs_data, rt_data
    );

    modport datapath (
        output rs_addr, rt_addr, wr_data,
        input  rs_data, rt_data
    );

    modport writer (
        output we, wr_addr
    );

endinterface

`default_nettype wire

// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int NUM_REGS = 32;
    localparam int REG_AW   = 5;
    localparam int DATA_W   = 32;
    localparam int CNT_W    = 16;
    localparam int IMM_W    = 16;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'd0;
    localparam logic [5:0] OP_ADDI  = 6'd8;
    localparam logic [5:0] OP_ANDI  = 6'd12;
    localparam logic [5:0] OP_ORI   = 6'd13;

    // R-type function codes
    localparam logic [5:0] FN_ADD = 6'd32;
    localparam logic [5:0] FN_SUB = 6'd34;
    localparam logic [5:0] FN_AND = 6'd36;
    localparam logic [5:0] FN_OR  = 6'd37;
    localparam logic [5:0] FN_XOR = 6'd38;
    localparam logic [5:0] FN_SLT = 6'd42;

    // Control FSM encoding
    localparam int         ST_W      = 2;
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_DECODE = 2'd1;
    localparam logic [1:0] ST_WRITE  = 2'd2;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_NONE
    } alu_op_e;

    typedef union packed {
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [4:0]        shamt;  // Not used by this unit
            logic [5:0]        funct;
        } r;
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [IMM_W-1:0]  imm16;
        } i;
    } instr_u;

endpackage

`default_nettype wire
